//--- logic/core_ctrl_pkg.sv
// Shared constants and types; 32 interrupt lines, only 3, 7, 11 and 16..31 are usable
package core_ctrl_pkg;

  //////////////////////////////////////////////////
  // Interrupt line widths
  //////////////////////////////////////////////////

  // Number of interrupt inputs
  localparam int unsigned IRQ_W    = 32;
  // Bits needed for an interrupt number
  localparam int unsigned IRQ_ID_W = 5;

  //////////////////////////////////////////////////
  // Interrupt line numbers
  //////////////////////////////////////////////////

  // Machine software interrupt
  localparam int unsigned IRQ_MSI     = 3;
  // Machine timer interrupt
  localparam int unsigned IRQ_MTI     = 7;
  // Machine external interrupt
  localparam int unsigned IRQ_MEI     = 11;
  // First fast line, fast lines run up to IRQ_W-1
  localparam int unsigned IRQ_FAST_LO = 16;

  // Lines 3, 7, 11 and 16..31 set, reserved lines cleared
  localparam logic [IRQ_W-1:0] IRQ_VALID_MASK = 32'hFFFF_0888;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Interrupt number
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // Core control FSM states
  typedef enum logic [1:0] {
    RESET,
    FUNCTIONAL,
    SLEEP,
    DEBUG_HALTED
  } ctrl_state_e;

endpackage

//--- logic/core_int_controller.sv
// Interrupt capture; irq_i must be synchronous to clk_i, outputs lag irq_i by one edge
`timescale 1ns/10ps

module core_int_controller import core_ctrl_pkg::*; (
  // Clock and reset
  input  logic             clk_i,
  input  logic             arst_n_i,

  // Raw interrupt lines
  input  logic [IRQ_W-1:0] irq_i,

  // Enable mask and global enable from outside
  input  logic [IRQ_W-1:0] mie_i,
  input  logic             mstatus_mie_i,

  // Towards the controller FSM
  output logic             irq_req_o,
  output irq_id_t          irq_id_o,
  output logic             irq_wu_o
);

  // Registered copy of the valid lines
  logic [IRQ_W-1:0] mip_q;
  // Lines both pending and enabled
  logic [IRQ_W-1:0] irq_pending;
  // Winning line number
  irq_id_t          irq_id_sel;

  //////////////////////////////////////////////////
  // Line capture
  //////////////////////////////////////////////////

  // Reserved lines never reach mip
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & IRQ_VALID_MASK;
    end
  end

  // Per-line enable
  assign irq_pending = mip_q & mie_i;

  //////////////////////////////////////////////////
  // Request and wakeup
  //////////////////////////////////////////////////

  // Wakeup ignores the global enable
  assign irq_wu_o  = |irq_pending;

  // Request only with global enable set
  assign irq_req_o = irq_wu_o & mstatus_mie_i;

  //////////////////////////////////////////////////
  // Fixed-priority encoder
  //////////////////////////////////////////////////

  // Later assignments override earlier ones
  // so the list runs from lowest to highest priority
  always_comb begin
    irq_id_sel = '0;

    // Timer is the lowest of the standard lines
    if (irq_pending[IRQ_MTI]) begin
      irq_id_sel = irq_id_t'(IRQ_MTI);
    end

    // Software beats timer
    if (irq_pending[IRQ_MSI]) begin
      irq_id_sel = irq_id_t'(IRQ_MSI);
    end

    // External beats software
    if (irq_pending[IRQ_MEI]) begin
      irq_id_sel = irq_id_t'(IRQ_MEI);
    end

    // Fast lines beat all standard lines
    // higher number wins
    for (int unsigned i = IRQ_FAST_LO; i < IRQ_W; i++) begin
      if (irq_pending[i]) begin
        irq_id_sel = irq_id_t'(i);
      end
    end
  end

  assign irq_id_o = irq_id_sel;

endmodule

//--- logic/core_sleep_unit.sv
// Sleep tracking; fetch enable is sticky until reset, busy_i may hold off sleep forever
`timescale 1ns/10ps

module core_sleep_unit (
  // Clock and reset
  input  logic clk_i,
  input  logic arst_n_i,

  // Core control inputs
  input  logic fetch_enable_i,
  input  logic wfi_i,
  input  logic busy_i,

  // Clear from the controller FSM
  input  logic wfi_clear_i,

  // Status towards the controller FSM
  output logic fetch_enable_o,
  output logic sleep_ready_o
);

  // Fetch enable seen at least once
  logic fetch_enable_q;
  // WFI executed and not yet consumed
  logic wfi_pending_q;

  //////////////////////////////////////////////////
  // Sticky fetch enable
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  assign fetch_enable_o = fetch_enable_q;

  //////////////////////////////////////////////////
  // WFI tracking
  //////////////////////////////////////////////////

  // New WFI takes priority over a clear in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wfi_pending_q <= 1'b0;
    end else if (wfi_i) begin
      wfi_pending_q <= 1'b1;
    end else if (wfi_clear_i) begin
      wfi_pending_q <= 1'b0;
    end
  end

  // Ready only once pipeline and memory are idle
  assign sleep_ready_o = wfi_pending_q & ~busy_i;

endmodule

//--- logic/core_controller.sv
// Core control FSM; debug_req_i is a level, dret_i a one-cycle pulse, outputs are registered
`timescale 1ns/10ps

module core_controller import core_ctrl_pkg::*; (
  // Clock and reset
  input  logic    clk_i,
  input  logic    arst_n_i,

  // From the sleep unit
  input  logic    fetch_enable_i,
  input  logic    sleep_ready_i,

  // From the interrupt controller
  input  logic    irq_req_i,
  input  irq_id_t irq_id_i,
  input  logic    irq_wu_i,

  // Debug requests
  input  logic    debug_req_i,
  input  logic    dret_i,

  // To the sleep unit
  output logic    wfi_clear_o,

  // Interrupt acknowledge
  output logic    irq_ack_o,
  output irq_id_t irq_id_o,

  // Core status
  output logic    debug_havereset_o,
  output logic    debug_running_o,
  output logic    debug_halted_o,
  output logic    core_sleep_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Acknowledge given, request not yet dropped
  logic    ack_pending_q;
  // Acknowledge taken this cycle
  logic    ack_take;

  // Output flops
  logic    irq_ack_q;
  irq_id_t irq_id_q;
  logic    havereset_q;
  logic    running_q;
  logic    halted_q;
  logic    sleep_q;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    ack_take    = 1'b0;
    wfi_clear_o = 1'b0;

    case (state_q)
      // Wait for fetch enable
      RESET: begin
        if (fetch_enable_i) begin
          state_d = FUNCTIONAL;
        end
      end

      // Debug, then interrupt, then sleep
      FUNCTIONAL: begin
        if (debug_req_i) begin
          state_d = DEBUG_HALTED;
        end else if (irq_req_i && !ack_pending_q) begin
          ack_take = 1'b1;
        end else if (sleep_ready_i) begin
          // WFI is consumed either way
          wfi_clear_o = 1'b1;
          // Pending line means no sleep at all
          if (!irq_wu_i) begin
            state_d = SLEEP;
          end
        end
      end

      // Wake on enabled line or debug
      SLEEP: begin
        if (irq_wu_i || debug_req_i) begin
          state_d = FUNCTIONAL;
        end
      end

      // Only dret leaves debug
      DEBUG_HALTED: begin
        if (dret_i) begin
          state_d = FUNCTIONAL;
        end
      end

      default: begin
        state_d = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // State and flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= RESET;
      ack_pending_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      // Held while the request stays, in every state
      ack_pending_q <= irq_req_i & (ack_pending_q | ack_take);
    end
  end

  //////////////////////////////////////////////////
  // Registered outputs
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_ack_q   <= 1'b0;
      irq_id_q    <= '0;
      havereset_q <= 1'b1;
      running_q   <= 1'b0;
      halted_q    <= 1'b0;
      sleep_q     <= 1'b0;
    end else begin
      // One-cycle acknowledge
      irq_ack_q   <= ack_take;
      // Number holds until the next acknowledge
      if (ack_take) begin
        irq_id_q <= irq_id_i;
      end
      // Drops on leaving RESET, never rises again
      havereset_q <= havereset_q & (state_d == RESET);
      running_q   <= (state_d == FUNCTIONAL) || (state_d == SLEEP);
      halted_q    <= (state_d == DEBUG_HALTED);
      sleep_q     <= (state_d == SLEEP);
    end
  end

  assign irq_ack_o         = irq_ack_q;
  assign irq_id_o          = irq_id_q;
  assign debug_havereset_o = havereset_q;
  assign debug_running_o   = running_q;
  assign debug_halted_o    = halted_q;
  assign core_sleep_o      = sleep_q;

endmodule

//--- logic/core_ctrl_top.sv
// Core control top; mie_i and mstatus_mie_i come from an external CSR file, one clock domain
`timescale 1ns/10ps

module core_ctrl_top import core_ctrl_pkg::*; (
  // Clock and reset
  input  logic             clk_i,
  input  logic             arst_n_i,

  // Core control
  input  logic             fetch_enable_i,
  input  logic             wfi_i,
  input  logic             busy_i,

  // Interrupts
  input  logic [IRQ_W-1:0] irq_i,
  input  logic [IRQ_W-1:0] mie_i,
  input  logic             mstatus_mie_i,
  output logic             irq_ack_o,
  output irq_id_t          irq_id_o,

  // Debug
  input  logic             debug_req_i,
  input  logic             dret_i,
  output logic             debug_havereset_o,
  output logic             debug_running_o,
  output logic             debug_halted_o,

  // Sleep status
  output logic             core_sleep_o
);

  // Interrupt controller to FSM
  logic    irq_req;
  irq_id_t irq_id;
  logic    irq_wu;

  // Sleep unit to FSM and back
  logic    fetch_enable;
  logic    sleep_ready;
  logic    wfi_clear;

  //////////////////////////////////////////////////
  // Interrupt controller
  //////////////////////////////////////////////////

  core_int_controller i_int_controller (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .irq_i         ( irq_i         ),
    .mie_i         ( mie_i         ),
    .mstatus_mie_i ( mstatus_mie_i ),
    .irq_req_o     ( irq_req       ),
    .irq_id_o      ( irq_id        ),
    .irq_wu_o      ( irq_wu        )
  );

  //////////////////////////////////////////////////
  // Sleep unit
  //////////////////////////////////////////////////

  core_sleep_unit i_sleep_unit (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .fetch_enable_i ( fetch_enable_i ),
    .wfi_i          ( wfi_i          ),
    .busy_i         ( busy_i         ),
    .wfi_clear_i    ( wfi_clear      ),
    .fetch_enable_o ( fetch_enable   ),
    .sleep_ready_o  ( sleep_ready    )
  );

  //////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////

  core_controller i_controller (
    .clk_i             ( clk_i             ),
    .arst_n_i          ( arst_n_i          ),
    .fetch_enable_i    ( fetch_enable      ),
    .sleep_ready_i     ( sleep_ready       ),
    .irq_req_i         ( irq_req           ),
    .irq_id_i          ( irq_id            ),
    .irq_wu_i          ( irq_wu            ),
    .debug_req_i       ( debug_req_i       ),
    .dret_i            ( dret_i            ),
    .wfi_clear_o       ( wfi_clear         ),
    .irq_ack_o         ( irq_ack_o         ),
    .irq_id_o          ( irq_id_o          ),
    .debug_havereset_o ( debug_havereset_o ),
    .debug_running_o   ( debug_running_o   ),
    .debug_halted_o    ( debug_halted_o    ),
    .core_sleep_o      ( core_sleep_o      )
  );

endmodule

//--- tb/tb_clock_gen.sv
// Testbench clock and reset; 4 ns period, reset released on a falling edge after 10 cycles
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // Half of the 4 ns period
  localparam int HALF_PERIOD_NS = 2;
  // Cycles with reset held low
  localparam int RST_CYCLES     = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

//--- tb/tb_core_ctrl.sv
// Table-driven test of core_ctrl_top; rows run back to back, each row starts on a falling edge
`timescale 1ns/10ps

module tb_core_ctrl;

  // Reset length as in the clock generator
  localparam int RST_CYCLES   = 10;
  localparam int SLACK_CYCLES = 50;
  localparam int N_RANDOM     = 8;
  localparam int unsigned RNG_SEED = 32'hfa219d8e;

  // Line patterns used by the table
  localparam logic [31:0] ALL_ON   = 32'hffff_ffff;
  localparam logic [31:0] MEI_LINE = 32'h0000_0800;
  localparam logic [31:0] MEI_OFF  = 32'hffff_f7ff;
  localparam logic [31:0] FAST16   = 32'h0001_0000;
  localparam logic [31:0] FAST20   = 32'h0010_0000;
  // Every line outside 3, 7, 11 and 16..31
  localparam logic [31:0] RESERVED = 32'h0000_f777;

  // One stimulus row with its expected results
  typedef struct packed {
    logic [31:0] irq;
    logic [31:0] mie;
    logic        mstatus_mie;
    logic        debug_req;
    logic        dret;
    logic        wfi;
    logic        busy;
    logic        fetch_enable;
    int          hold;
    int          exp_ack;
    int          exp_sleep;
    logic [4:0]  exp_id;
    logic        exp_havereset;
    logic        exp_running;
    logic        exp_halted;
  } row_t;

  logic        clk;
  logic        arst_n;
  logic        fetch_enable_i;
  logic        wfi_i;
  logic        busy_i;
  logic [31:0] irq_i;
  logic [31:0] mie_i;
  logic        mstatus_mie_i;
  logic        debug_req_i;
  logic        dret_i;
  logic        irq_ack_o;
  logic [4:0]  irq_id_o;
  logic        debug_havereset_o;
  logic        debug_running_o;
  logic        debug_halted_o;
  logic        core_sleep_o;

  row_t        rows[$];
  int          errors = 0;
  int          checks = 0;
  int unsigned cycle_cnt = 0;
  // Zero until the table length is known
  int unsigned cycle_limit = 0;

  tb_clock_gen i_clock_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  core_ctrl_top i_dut (
    .clk_i             ( clk               ),
    .arst_n_i          ( arst_n            ),
    .fetch_enable_i    ( fetch_enable_i    ),
    .wfi_i             ( wfi_i             ),
    .busy_i            ( busy_i            ),
    .irq_i             ( irq_i             ),
    .mie_i             ( mie_i             ),
    .mstatus_mie_i     ( mstatus_mie_i     ),
    .irq_ack_o         ( irq_ack_o         ),
    .irq_id_o          ( irq_id_o          ),
    .debug_req_i       ( debug_req_i       ),
    .dret_i            ( dret_i            ),
    .debug_havereset_o ( debug_havereset_o ),
    .debug_running_o   ( debug_running_o   ),
    .debug_halted_o    ( debug_halted_o    ),
    .core_sleep_o      ( core_sleep_o      )
  );

  ////////////////////////////////////////////////////
  // Reference model helpers
  ////////////////////////////////////////////////////

  // Lines 3, 7, 11 and the fast lines 16..31
  function automatic logic [31:0] valid_lines();
    logic [31:0] m;
    m     = '0;
    m[3]  = 1'b1;
    m[7]  = 1'b1;
    m[11] = 1'b1;
    for (int i = 16; i < 32; i++) begin
      m[i] = 1'b1;
    end
    return m;
  endfunction

  // Highest fast line first, then external, software, timer
  function automatic logic [4:0] winning_line(input logic [31:0] pend);
    logic [4:0] id;
    logic       found;
    id    = 5'd0;
    found = 1'b0;
    for (int i = 31; i >= 16; i--) begin
      if (!found && pend[i]) begin
        id    = 5'(i);
        found = 1'b1;
      end
    end
    if (!found && pend[11]) begin
      id    = 5'd11;
      found = 1'b1;
    end
    if (!found && pend[3]) begin
      id    = 5'd3;
      found = 1'b1;
    end
    if (!found && pend[7]) begin
      id = 5'd7;
    end
    return id;
  endfunction

  ////////////////////////////////////////////////////
  // Table build, drive and compare
  ////////////////////////////////////////////////////

  task automatic add_row(input logic [31:0] irq, input logic [31:0] mie, input int mst,
                         input int dbg, input int dret, input int wfi, input int busy,
                         input int fe, input int hold, input int ack, input int slp,
                         input logic [4:0] id, input int hrst, input int run, input int halt);
    row_t r;
    r.irq           = irq;
    r.mie           = mie;
    r.mstatus_mie   = (mst != 0);
    r.debug_req     = (dbg != 0);
    r.dret          = (dret != 0);
    r.wfi           = (wfi != 0);
    r.busy          = (busy != 0);
    r.fetch_enable  = (fe != 0);
    r.hold          = hold;
    r.exp_ack       = ack;
    r.exp_sleep     = slp;
    r.exp_id        = id;
    r.exp_havereset = (hrst != 0);
    r.exp_running   = (run != 0);
    r.exp_halted    = (halt != 0);
    rows.push_back(r);
  endtask

  task automatic check_value(input string name, input int idx, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s row %0d: got %h expected %h", name, idx, got, exp);
      errors++;
    end
  endtask

  // Called on a falling edge; leaves on a falling edge
  task automatic apply_row(input row_t r, input int idx);
    int ack_cnt;
    int slp_cnt;
    ack_cnt        = 0;
    slp_cnt        = 0;
    irq_i          = r.irq;
    mie_i          = r.mie;
    mstatus_mie_i  = r.mstatus_mie;
    debug_req_i    = r.debug_req;
    dret_i         = r.dret;
    wfi_i          = r.wfi;
    busy_i         = r.busy;
    fetch_enable_i = r.fetch_enable;
    for (int c = 0; c < r.hold; c++) begin
      @(posedge clk);
      @(negedge clk);
      if (irq_ack_o) begin
        ack_cnt++;
      end
      if (core_sleep_o) begin
        slp_cnt++;
      end
      // Pulses last one cycle
      dret_i = 1'b0;
      wfi_i  = 1'b0;
    end
    check_value("irq_ack_o cycles", idx, ack_cnt, r.exp_ack);
    check_value("core_sleep_o cycles", idx, slp_cnt, r.exp_sleep);
    check_value("irq_id_o", idx, 32'(irq_id_o), 32'(r.exp_id));
    check_value("debug_havereset_o", idx, 32'(debug_havereset_o), 32'(r.exp_havereset));
    check_value("debug_running_o", idx, 32'(debug_running_o), 32'(r.exp_running));
    check_value("debug_halted_o", idx, 32'(debug_halted_o), 32'(r.exp_halted));
  endtask

  ////////////////////////////////////////////////////
  // Timeout
  ////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: run took more than %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////

  initial begin
    logic [31:0] pat;
    logic [4:0]  last_id;
    int unsigned total;
    fetch_enable_i = 1'b0;
    wfi_i          = 1'b0;
    busy_i         = 1'b0;
    irq_i          = '0;
    mie_i          = '0;
    mstatus_mie_i  = 1'b0;
    debug_req_i    = 1'b0;
    dret_i         = 1'b0;
    void'($urandom(RNG_SEED));

    // irq  mie  mst dbg dret wfi busy fe hold | ack slp id hrst run halt
    // Reset exit held off until fetch enable
    add_row('0, '0, 0, 0, 0, 0, 0, 0, 5, 0, 0, 5'd0, 1, 0, 0);
    add_row('0, '0, 0, 0, 0, 0, 0, 1, 3, 0, 0, 5'd0, 0, 1, 0);
    // Global enable, per-line mask, one ack per request
    add_row(MEI_LINE, ALL_ON,  0, 0, 0, 0, 0, 1, 4, 0, 0, 5'd0,  0, 1, 0);
    add_row(MEI_LINE, ALL_ON,  1, 0, 0, 0, 0, 1, 4, 1, 0, 5'd11, 0, 1, 0);
    add_row(MEI_LINE, ALL_ON,  1, 0, 0, 0, 0, 1, 6, 0, 0, 5'd11, 0, 1, 0);
    add_row('0,       ALL_ON,  1, 0, 0, 0, 0, 1, 3, 0, 0, 5'd11, 0, 1, 0);
    add_row(MEI_LINE, MEI_OFF, 1, 0, 0, 0, 0, 1, 4, 0, 0, 5'd11, 0, 1, 0);
    add_row(MEI_LINE, ALL_ON,  1, 0, 0, 0, 0, 1, 4, 1, 0, 5'd11, 0, 1, 0);
    add_row('0,       ALL_ON,  1, 0, 0, 0, 0, 1, 3, 0, 0, 5'd11, 0, 1, 0);
    // Random patterns each followed by a quiet row
    for (int k = 0; k < N_RANDOM; k++) begin
      pat = $urandom() & valid_lines();
      // Odd rows exercise the standard lines only
      if (k % 2 == 1) begin
        pat = pat & 32'h0000_ffff;
      end
      if (pat == '0) begin
        pat = 32'h0000_0080;
      end
      last_id = winning_line(pat);
      add_row(pat, ALL_ON, 1, 0, 0, 0, 0, 1, 4, 1, 0, last_id, 0, 1, 0);
      add_row('0,  ALL_ON, 1, 0, 0, 0, 0, 1, 3, 0, 0, last_id, 0, 1, 0);
    end
    add_row(RESERVED, ALL_ON, 1, 0, 0, 0, 0, 1, 4, 0, 0, last_id, 0, 1, 0);
    // Debug halt with a pending line, then wake from sleep into debug
    add_row('0,     ALL_ON, 1, 1, 0, 0, 0, 1, 3, 0, 0, last_id, 0, 0, 1);
    add_row(FAST20, ALL_ON, 1, 0, 0, 0, 0, 1, 5, 0, 0, last_id, 0, 0, 1);
    add_row(FAST20, ALL_ON, 1, 0, 1, 0, 0, 1, 4, 1, 0, 5'd20,   0, 1, 0);
    add_row('0,     ALL_ON, 1, 0, 0, 0, 0, 1, 3, 0, 0, 5'd20,   0, 1, 0);
    add_row('0,     ALL_ON, 1, 0, 0, 1, 0, 1, 3, 0, 2, 5'd20,   0, 1, 0);
    add_row('0,     ALL_ON, 1, 1, 0, 0, 0, 1, 3, 0, 0, 5'd20,   0, 0, 1);
    add_row('0,     ALL_ON, 1, 0, 1, 0, 0, 1, 3, 0, 0, 5'd20,   0, 1, 0);
    // WFI against busy, wakeup without global enable
    add_row('0,     ALL_ON, 0, 0, 0, 1, 1, 1, 4, 0, 0, 5'd20,   0, 1, 0);
    add_row('0,     ALL_ON, 0, 0, 0, 0, 0, 1, 3, 0, 3, 5'd20,   0, 1, 0);
    add_row(FAST16, ALL_ON, 0, 0, 0, 0, 0, 1, 4, 0, 1, 5'd20,   0, 1, 0);
    add_row(FAST16, ALL_ON, 0, 0, 0, 1, 0, 1, 4, 0, 0, 5'd20,   0, 1, 0);
    add_row('0,     ALL_ON, 0, 0, 0, 0, 0, 1, 3, 0, 0, 5'd20,   0, 1, 0);

    total = 0;
    for (int i = 0; i < rows.size(); i++) begin
      total += rows[i].hold;
    end
    cycle_limit = total + RST_CYCLES + SLACK_CYCLES;

    // Reset ends on a falling edge
    @(posedge arst_n);
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(rows[i], i);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- files.f
logic/core_ctrl_pkg.sv
logic/core_int_controller.sv
logic/core_sleep_unit.sv
logic/core_controller.sv
logic/core_ctrl_top.sv
tb/tb_clock_gen.sv
tb/tb_core_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the core control regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core_ctrl -f files.f -o tb_sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/tb_sim | tee /dev/stderr | grep -q "Regression passed" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
